// File: Bender.yml
package:
  name: rv_core

sources:
  - design/rv_pkg.sv
  - design/inst_cycle_ctrl.sv
  - design/id_stage.sv
  - design/regfile.sv
  - design/ex_stage.sv
  - design/wb_stage.sv
  - design/rv_core.sv
  - target: test
    files:
      - sim/tb_rv_core.sv

// File: design/ex_stage.sv
// execute stage, holds the decode result and registers the alu result and next pc
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
  input  wire                      clk,
  input  wire                      rst,
  input  wire rv_pkg::phase_e      phase,
  input  wire  [rv_pkg::XLEN-1:0]  pc,
  input  wire rv_pkg::decode_t     dec,
  output rv_pkg::decode_t          dec_q,
  output logic [rv_pkg::XLEN-1:0]  alu_result,
  output logic [rv_pkg::XLEN-1:0]  next_pc
);
  import rv_pkg::*;

  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic [XLEN-1:0] alu;
  logic [XLEN-1:0] npc;
  logic            taken;

  // decode output is only valid in PH_ID
  always_ff @(posedge clk) begin
    if (rst) begin
      dec_q <= '0;
    end else if (phase == PH_ID) begin
      dec_q <= dec;
    end
  end

  assign sum  = dec_q.op1 + dec_q.op2;
  assign diff = dec_q.op1 - dec_q.op2;

  always_comb begin
    case (dec_q.opcode)
      OP_OP:      alu = dec_q.funct7[5] ? diff : sum;
      OP_OPIMM32: alu = {{32{sum[31]}}, sum[31:0]};
      OP_JAL:     alu = dec_q.op1;
      OP_JALR:    alu = dec_q.t1;
      // lui, auipc, addi and memory addresses
      default:    alu = sum;
    endcase
  end

  // beq on funct3 000, bne on 001
  always_comb begin
    taken = 1'b0;
    if (dec_q.itype == IT_B) begin
      case (dec_q.funct3)
        3'b000:  taken = (dec_q.op1 == dec_q.op2);
        3'b001:  taken = (dec_q.op1 != dec_q.op2);
        default: taken = 1'b0;
      endcase
    end
  end

  always_comb begin
    case (dec_q.opcode)
      OP_JAL:  npc = dec_q.op2;
      OP_JALR: npc = {sum[XLEN-1:1], 1'b0};
      default: npc = taken ? dec_q.t1 : pc + 64'd4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (phase == PH_EX) begin
      alu_result <= alu;
      next_pc    <= npc;
    end
  end

endmodule

`default_nettype wire

// File: design/id_stage.sv
// decode stage, turns the latched instruction into operands and controls during PH_ID
`timescale 1ns/100ps
`default_nettype none

module id_stage (
  input  wire rv_pkg::phase_e      phase,
  input  wire  [31:0]              inst,
  input  wire  [rv_pkg::XLEN-1:0]  pc,
  input  wire  [rv_pkg::XLEN-1:0]  rs1_data,
  input  wire  [rv_pkg::XLEN-1:0]  rs2_data,
  output logic [4:0]               rs1,
  output logic [4:0]               rs2,
  output logic                     rs1_ren,
  output logic                     rs2_ren,
  output rv_pkg::decode_t          dec
);
  import rv_pkg::*;

  logic            id_active;
  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  itype_e          itype;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm;
  logic            reg_wen;
  logic            mem_ren;
  logic            mem_wen;
  logic [7:0]      wmask;

  assign id_active = (phase == PH_ID);
  assign opcode    = opcode_e'(inst[6:2]);
  assign funct3    = inst[14:12];
  assign funct7    = inst[31:25];

  // immediates, all sign-extended to 64 bits
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      OP_LUI, OP_AUIPC: itype = IT_U;
      OP_JAL:           itype = IT_J;
      OP_BRANCH:        itype = IT_B;
      OP_STORE:         itype = IT_S;
      OP_OP:            itype = IT_R;
      OP_JALR, OP_LOAD, OP_OPIMM, OP_OPIMM32, OP_FENCE, OP_SYSTEM:
        itype = IT_I;
      default:          itype = IT_NONE;
    endcase
  end

  always_comb begin
    case (itype)
      IT_I:    imm = imm_i;
      IT_S:    imm = imm_s;
      IT_B:    imm = imm_b;
      IT_U:    imm = imm_u;
      IT_J:    imm = imm_j;
      default: imm = '0;
    endcase
  end

  // only the kept subset writes rd, everything else retires as a no-op
  always_comb begin
    case (opcode)
      OP_LUI, OP_AUIPC, OP_JAL: reg_wen = 1'b1;
      OP_JALR:                  reg_wen = (funct3 == 3'b000);
      OP_LOAD:                  reg_wen = (funct3 != 3'b111);
      OP_OPIMM, OP_OPIMM32:     reg_wen = (funct3 == 3'b000);
      OP_OP:
        reg_wen = (funct3 == 3'b000) && ((funct7 == 7'h00) || (funct7 == 7'h20));
      default:                  reg_wen = 1'b0;
    endcase
  end

  assign mem_ren = (opcode == OP_LOAD) && (funct3 != 3'b111);
  assign mem_wen = (opcode == OP_STORE) && !funct3[2];

  // byte lanes before the address shift
  always_comb begin
    case (funct3[1:0])
      2'b00:   wmask = 8'h01;
      2'b01:   wmask = 8'h03;
      2'b10:   wmask = 8'h0f;
      default: wmask = 8'hff;
    endcase
  end

  // register read addresses, silent outside decode
  assign rs1     = id_active ? inst[19:15] : 5'd0;
  assign rs2     = id_active ? inst[24:20] : 5'd0;
  assign rs1_ren = id_active && (itype inside {IT_R, IT_I, IT_S, IT_B});
  assign rs2_ren = id_active && (itype inside {IT_R, IT_S, IT_B});

  always_comb begin
    dec = '0;
    if (id_active) begin
      dec.rs2_data  = rs2_data;
      dec.rd        = inst[11:7];
      dec.funct3    = funct3;
      dec.funct7    = funct7;
      dec.opcode    = opcode;
      dec.itype     = itype;
      dec.reg_wen   = reg_wen;
      dec.mem_ren   = mem_ren;
      dec.mem_wen   = mem_wen;
      dec.mem_wmask = mem_wen ? wmask : 8'h00;
      case (itype)
        IT_R, IT_B: begin
          dec.op1 = rs1_data;
          dec.op2 = rs2_data;
        end
        IT_I, IT_S: begin
          dec.op1 = rs1_data;
          dec.op2 = imm;
        end
        // link value in op1, jump target in op2
        IT_J: begin
          dec.op1 = pc + 64'd4;
          dec.op2 = pc + imm;
        end
        IT_U: begin
          dec.op1 = (opcode == OP_AUIPC) ? pc : '0;
          dec.op2 = imm;
        end
        default: begin
          dec.op1 = '0;
          dec.op2 = '0;
        end
      endcase
      // jalr carries its link here, branches their target
      if (opcode == OP_JALR) begin
        dec.t1 = pc + 64'd4;
      end else if (opcode == OP_BRANCH) begin
        dec.t1 = pc + imm;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/inst_cycle_ctrl.sv
// phase sequencer and program counter, fetches one instruction per five-cycle round
`timescale 1ns/100ps
`default_nettype none

module inst_cycle_ctrl #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire  [31:0]              inst_rdata,
  input  wire  [rv_pkg::XLEN-1:0]  next_pc,
  input  wire                      pc_load,
  output rv_pkg::phase_e           phase,
  output logic [rv_pkg::XLEN-1:0]  pc,
  output logic [rv_pkg::XLEN-1:0]  inst_addr,
  output logic [31:0]              inst
);
  import rv_pkg::*;

  // five fixed phases, then back to fetch
  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= PH_IF;
    end else begin
      case (phase)
        PH_IF:   phase <= PH_ID;
        PH_ID:   phase <= PH_EX;
        PH_EX:   phase <= PH_MEM;
        PH_MEM:  phase <= PH_WB;
        default: phase <= PH_IF;
      endcase
    end
  end

  // pc only moves at writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (pc_load) begin
      pc <= next_pc;
    end
  end

  // instruction memory answers in the same cycle
  always_ff @(posedge clk) begin
    if (phase == PH_IF) begin
      inst <= inst_rdata;
    end
  end

  assign inst_addr = pc;

endmodule

`default_nettype wire

// File: design/regfile.sv
// integer register file, x0 reads as zero, two read ports and one write port
`timescale 1ns/100ps
`default_nettype none

module regfile (
  input  wire                      clk,
  input  wire                      rst,
  input  wire  [4:0]               rs1,
  input  wire  [4:0]               rs2,
  input  wire                      rs1_ren,
  input  wire                      rs2_ren,
  input  wire                      wen,
  input  wire  [4:0]               waddr,
  input  wire  [rv_pkg::XLEN-1:0]  wdata,
  output logic [rv_pkg::XLEN-1:0]  rs1_data,
  output logic [rv_pkg::XLEN-1:0]  rs2_data
);
  import rv_pkg::*;

  // x1..x31, x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rs1_data = (rs1_ren && (rs1 != 5'd0)) ? regs[rs1] : '0;
  assign rs2_data = (rs2_ren && (rs2 != 5'd0)) ? regs[rs2] : '0;

endmodule

`default_nettype wire

// File: design/rv_core.sv
// top of the multi-cycle rv64i core, exposes instruction, data and commit ports
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  wire                      clk,
  input  wire                      rst,
  output logic [rv_pkg::XLEN-1:0]  inst_addr,
  input  wire  [31:0]              inst_rdata,
  output logic                     dmem_ren,
  output logic                     dmem_wen,
  output logic [rv_pkg::XLEN-1:0]  dmem_addr,
  output logic [rv_pkg::XLEN-1:0]  dmem_wdata,
  output logic [7:0]               dmem_wmask,
  input  wire  [rv_pkg::XLEN-1:0]  dmem_rdata,
  output logic                     commit_valid,
  output rv_pkg::commit_t          commit
);
  import rv_pkg::*;

  phase_e          phase;
  logic [XLEN-1:0] pc;
  logic [31:0]     inst;
  logic [XLEN-1:0] next_pc;
  logic            pc_load;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic            rs1_ren;
  logic            rs2_ren;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  decode_t         dec;
  decode_t         dec_q;
  logic [XLEN-1:0] alu_result;
  logic            rf_wen;
  logic [4:0]      rf_waddr;
  logic [XLEN-1:0] rf_wdata;

  inst_cycle_ctrl #(
    .RESET_PC (RESET_PC)
  ) i_inst_cycle_ctrl (
    .clk        (clk),
    .rst        (rst),
    .inst_rdata (inst_rdata),
    .next_pc    (next_pc),
    .pc_load    (pc_load),
    .phase      (phase),
    .pc         (pc),
    .inst_addr  (inst_addr),
    .inst       (inst)
  );

  id_stage i_id_stage (
    .phase    (phase),
    .inst     (inst),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_ren  (rs1_ren),
    .rs2_ren  (rs2_ren),
    .dec      (dec)
  );

  regfile i_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_ren  (rs1_ren),
    .rs2_ren  (rs2_ren),
    .wen      (rf_wen),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  ex_stage i_ex_stage (
    .clk        (clk),
    .rst        (rst),
    .phase      (phase),
    .pc         (pc),
    .dec        (dec),
    .dec_q      (dec_q),
    .alu_result (alu_result),
    .next_pc    (next_pc)
  );

  wb_stage i_wb_stage (
    .clk          (clk),
    .rst          (rst),
    .phase        (phase),
    .pc           (pc),
    .dec_q        (dec_q),
    .alu_result   (alu_result),
    .dmem_rdata   (dmem_rdata),
    .dmem_ren     (dmem_ren),
    .dmem_wen     (dmem_wen),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_wmask   (dmem_wmask),
    .rf_wen       (rf_wen),
    .rf_waddr     (rf_waddr),
    .rf_wdata     (rf_wdata),
    .pc_load      (pc_load),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

endmodule

`default_nettype wire

// File: design/rv_pkg.sv
// shared types for the multi-cycle rv64i core, imported by every design file
`default_nettype none

package rv_pkg;

  // data-path width for pc, registers and memory data
  localparam int XLEN = 64;

  // kept major opcodes, inst[6:2]
  typedef enum logic [4:0] {
    OP_LOAD    = 5'b00000,
    OP_FENCE   = 5'b00011,
    OP_OPIMM   = 5'b00100,
    OP_AUIPC   = 5'b00101,
    OP_OPIMM32 = 5'b00110,
    OP_STORE   = 5'b01000,
    OP_OP      = 5'b01100,
    OP_LUI     = 5'b01101,
    OP_BRANCH  = 5'b11000,
    OP_JALR    = 5'b11001,
    OP_JAL     = 5'b11011,
    OP_SYSTEM  = 5'b11100
  } opcode_e;

  // instruction formats, zero means nothing decoded
  typedef enum logic [2:0] {
    IT_NONE = 3'd0,
    IT_R    = 3'd1,
    IT_I    = 3'd2,
    IT_S    = 3'd3,
    IT_B    = 3'd4,
    IT_U    = 3'd5,
    IT_J    = 3'd6
  } itype_e;

  // instruction-cycle phases
  typedef enum logic [2:0] {
    PH_IF  = 3'd0,
    PH_ID  = 3'd1,
    PH_EX  = 3'd2,
    PH_MEM = 3'd3,
    PH_WB  = 3'd4
  } phase_e;

  // decode result handed from id to ex
  typedef struct packed {
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] t1;
    logic [XLEN-1:0] rs2_data;
    logic [4:0]      rd;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    opcode_e         opcode;
    itype_e          itype;
    logic            reg_wen;
    logic            mem_ren;
    logic            mem_wen;
    logic [7:0]      mem_wmask;
  } decode_t;

  // retirement record
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [4:0]      rd;
    logic [XLEN-1:0] wdata;
    logic            wen;
  } commit_t;

endpackage

`default_nettype wire

// File: design/wb_stage.sv
// memory and writeback, drives data-memory strobes, extends loads, commits the result
`timescale 1ns/100ps
`default_nettype none

module wb_stage (
  input  wire                      clk,
  input  wire                      rst,
  input  wire rv_pkg::phase_e      phase,
  input  wire  [rv_pkg::XLEN-1:0]  pc,
  input  wire rv_pkg::decode_t     dec_q,
  input  wire  [rv_pkg::XLEN-1:0]  alu_result,
  input  wire  [rv_pkg::XLEN-1:0]  dmem_rdata,
  output logic                     dmem_ren,
  output logic                     dmem_wen,
  output logic [rv_pkg::XLEN-1:0]  dmem_addr,
  output logic [rv_pkg::XLEN-1:0]  dmem_wdata,
  output logic [7:0]               dmem_wmask,
  output logic                     rf_wen,
  output logic [4:0]               rf_waddr,
  output logic [rv_pkg::XLEN-1:0]  rf_wdata,
  output logic                     pc_load,
  output logic                     commit_valid,
  output rv_pkg::commit_t          commit
);
  import rv_pkg::*;

  logic            mem_active;
  logic            wb_active;
  logic [5:0]      lane_shift;
  logic [XLEN-1:0] load_q;
  logic [XLEN-1:0] load_ext;
  logic [XLEN-1:0] wb_data;

  assign mem_active = (phase == PH_MEM);
  assign wb_active  = (phase == PH_WB);
  // bit offset of the addressed byte inside the dword
  assign lane_shift = {alu_result[2:0], 3'b000};

  assign dmem_ren   = mem_active && dec_q.mem_ren;
  assign dmem_wen   = mem_active && dec_q.mem_wen;
  assign dmem_addr  = (dmem_ren || dmem_wen) ? alu_result : '0;
  assign dmem_wdata = dmem_wen ? (dec_q.rs2_data << lane_shift) : '0;
  assign dmem_wmask = dmem_wen ? (dec_q.mem_wmask << alu_result[2:0]) : 8'h00;

  // load data brought down to bit 0 as it is captured
  always_ff @(posedge clk) begin
    if (rst) begin
      load_q <= '0;
    end else if (mem_active) begin
      load_q <= dmem_rdata >> lane_shift;
    end
  end

  always_comb begin
    case (dec_q.funct3)
      3'b000:  load_ext = {{56{load_q[7]}}, load_q[7:0]};
      3'b001:  load_ext = {{48{load_q[15]}}, load_q[15:0]};
      3'b010:  load_ext = {{32{load_q[31]}}, load_q[31:0]};
      3'b100:  load_ext = {56'd0, load_q[7:0]};
      3'b101:  load_ext = {48'd0, load_q[15:0]};
      3'b110:  load_ext = {32'd0, load_q[31:0]};
      default: load_ext = load_q;
    endcase
  end

  assign wb_data = dec_q.mem_ren ? load_ext : alu_result;

  assign rf_wen   = wb_active && dec_q.reg_wen && (dec_q.rd != 5'd0);
  assign rf_waddr = dec_q.rd;
  assign rf_wdata = wb_data;

  // one commit per instruction, pc follows in the same cycle
  assign pc_load      = wb_active;
  assign commit_valid = wb_active;
  assign commit.pc    = pc;
  assign commit.rd    = dec_q.rd;
  assign commit.wdata = wb_data;
  assign commit.wen   = rf_wen;

endmodule

`default_nettype wire

// File: project.f
design/rv_pkg.sv
design/inst_cycle_ctrl.sv
design/id_stage.sv
design/regfile.sv
design/ex_stage.sv
design/wb_stage.sv
design/rv_core.sv
sim/tb_rv_core.sv

// File: sim/tb_rv_core.sv
// testbench for rv_core, runs a random program and checks commits and stores against a model
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;
  import rv_pkg::*;

  localparam int          CLK_PERIOD  = 20;
  localparam int          DRIVE_DELAY = 2;
  localparam int          RST_CYCLES  = 16;
  localparam int          PROG_LEN    = 200;
  localparam int          N_COMMITS   = 300;
  localparam int          TIMEOUT_NS  = (RST_CYCLES + N_COMMITS * 5 + 50) * CLK_PERIOD;
  localparam logic [63:0] RESET_PC    = 64'd0;
  localparam logic [63:0] FINAL_PC    = (PROG_LEN - 1) * 4;
  localparam logic [31:0] NOP_WORD    = 32'h0000_0013;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [63:0] inst_addr;
  logic [31:0] inst_rdata;
  logic        dmem_ren;
  logic        dmem_wen;
  logic [63:0] dmem_addr;
  logic [63:0] dmem_wdata;
  logic [7:0]  dmem_wmask;
  logic [63:0] dmem_rdata;
  logic        commit_valid;
  commit_t     commit;

  // program, memory seen by the DUT, and the model's own state
  logic [31:0] prog [0:255];
  logic [7:0]  dmem [0:4095];
  logic [7:0]  mmem [0:4095];
  logic [63:0] xreg [0:31];
  logic [11:0] dword_base;
  integer      seed = 32'h6088_db47;
  int          cyc = 0;
  int          n_commits = 0;

  // expectations for the instruction now in flight
  logic [63:0] m_pc;
  logic [63:0] exp_pc;
  logic [4:0]  exp_rd;
  logic        exp_wen;
  logic [63:0] exp_wdata;
  logic        exp_load;
  logic        exp_store;
  logic [63:0] exp_addr;
  logic [63:0] exp_sdata;
  logic [7:0]  exp_smask;

  rv_core #(
    .RESET_PC (RESET_PC)
  ) i_rv_core (
    .clk          (clk),
    .rst          (rst),
    .inst_addr    (inst_addr),
    .inst_rdata   (inst_rdata),
    .dmem_ren     (dmem_ren),
    .dmem_wen     (dmem_wen),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_wmask   (dmem_wmask),
    .dmem_rdata   (dmem_rdata),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // both memories answer in the same cycle
  assign inst_rdata = prog[inst_addr[9:2]];
  // data memory is read and written by whole dwords
  assign dword_base = {dmem_addr[11:3], 3'b000};
  assign dmem_rdata = {dmem[dword_base + 7], dmem[dword_base + 6], dmem[dword_base + 5],
                       dmem[dword_base + 4], dmem[dword_base + 3], dmem[dword_base + 2],
                       dmem[dword_base + 1], dmem[dword_base]};

  always @(posedge clk) begin
    if (!rst && dmem_wen) begin
      for (int i = 0; i < 8; i++) begin
        if (dmem_wmask[i]) begin
          dmem[dword_base + i] <= dmem_wdata[8*i +: 8];
        end
      end
    end
  end

  function automatic logic [31:0] utype_word(input logic [6:0] opc, input logic [4:0] rd,
                                             input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] itype_word(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] stype_word(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] btype_word(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] jtype_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, 7'h33};
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("ERR %0d ns: %s is %h, expected %h", $time, name, actual, expected));
    end
  endtask

  task automatic gen_program;
    logic [31:0] r;
    logic [31:0] f;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    int          lim;
    int          k;
    for (int i = 0; i < 256; i++) begin
      prog[i] = NOP_WORD;
    end
    // x1..x7 get random values from lui and addi pairs
    for (int n = 1; n < 8; n++) begin
      r  = $random(seed);
      rd = n;
      prog[2*n-2] = utype_word(7'h37, rd, r[31:12]);
      prog[2*n-1] = itype_word(7'h13, 3'b000, rd, rd, r[11:0]);
    end
    for (int idx = 14; idx < PROG_LEN - 1; idx++) begin
      r   = $random(seed);
      f   = $random(seed);
      rd  = {2'b00, r[6:4]};
      rs1 = {2'b00, r[9:7]};
      rs2 = r[10] ? rs1 : {2'b00, r[13:11]};
      // forward targets that never pass the final loop
      lim = (PROG_LEN - 1 - idx < 16) ? PROG_LEN - 1 - idx : 16;
      k   = 1 + f[27:20] % lim;
      case (r[3:0])
        4'd0:       prog[idx] = utype_word(7'h37, rd, f[19:0]);
        4'd1:       prog[idx] = utype_word(7'h17, rd, f[19:0]);
        4'd2, 4'd3: prog[idx] = itype_word(7'h13, 3'b000, rd, rs1, f[11:0]);
        4'd4:       prog[idx] = itype_word(7'h1b, 3'b000, rd, rs1, f[11:0]);
        4'd5:       prog[idx] = rtype_word(7'h00, rs2, rs1, rd);
        4'd6:       prog[idx] = rtype_word(7'h20, rs2, rs1, rd);
        4'd7, 4'd8: begin
          f3  = f[2:0] % 3'd7;
          imm = {1'b0, f[14:4]} & ~((12'd1 << f3[1:0]) - 12'd1);
          prog[idx] = itype_word(7'h03, f3, rd, 5'd0, imm);
        end
        4'd9, 4'd10: begin
          f3  = {1'b0, f[1:0]};
          imm = {1'b0, f[14:4]} & ~((12'd1 << f3[1:0]) - 12'd1);
          prog[idx] = stype_word(f3, 5'd0, rs2, imm);
        end
        4'd11, 4'd12: prog[idx] = btype_word({2'b00, f[8]}, rs1, rs2, k * 4);
        4'd13:        prog[idx] = jtype_word(rd, k * 4);
        4'd14: begin
          // bit 0 of an odd immediate drops out of the target
          imm = (idx + k) * 4 + f[9];
          prog[idx] = itype_word(7'h67, 3'b000, rd, 5'd0, imm);
        end
        default: prog[idx] = f[0] ? 32'h0000_000f : 32'h0000_0073;
      endcase
    end
    prog[PROG_LEN-1] = jtype_word(5'd0, 21'd0);
  endtask

  // executes the instruction at m_pc and records what the DUT must show for it
  task automatic step_model;
    logic [31:0] ins;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_b;
    logic [63:0] imm_u;
    logic [63:0] imm_j;
    logic [63:0] res;
    logic [63:0] npc;
    logic [63:0] val;
    logic [63:0] addr;
    logic        writes;
    int          w;
    ins   = prog[m_pc[9:2]];
    a     = xreg[ins[19:15]];
    b     = xreg[ins[24:20]];
    imm_i = {{52{ins[31]}}, ins[31:20]};
    imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {{32{ins[31]}}, ins[31:12], 12'h000};
    imm_j = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    res       = '0;
    npc       = m_pc + 64'd4;
    writes    = 1'b0;
    exp_load  = 1'b0;
    exp_store = 1'b0;
    exp_addr  = '0;
    exp_sdata = '0;
    exp_smask = '0;
    w         = 1 << ins[13:12];
    case (ins[6:0])
      7'h37: begin
        res    = imm_u;
        writes = 1'b1;
      end
      7'h17: begin
        res    = m_pc + imm_u;
        writes = 1'b1;
      end
      7'h6f: begin
        res    = m_pc + 64'd4;
        npc    = m_pc + imm_j;
        writes = 1'b1;
      end
      7'h67: begin
        res    = m_pc + 64'd4;
        npc    = (a + imm_i) & ~64'd1;
        writes = 1'b1;
      end
      7'h63: begin
        if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
          npc = m_pc + imm_b;
        end
      end
      7'h03: begin
        addr     = a + imm_i;
        exp_load = 1'b1;
        exp_addr = addr;
        val      = '0;
        for (int i = 0; i < w; i++) begin
          val[8*i +: 8] = mmem[addr[11:0] + i];
        end
        res = val;
        // signed loads copy the top loaded bit upward
        if (!ins[14]) begin
          for (int i = 8 * w; i < 64; i++) begin
            res[i] = val[8*w-1];
          end
        end
        writes = 1'b1;
      end
      7'h23: begin
        addr      = a + imm_s;
        exp_store = 1'b1;
        exp_addr  = addr;
        exp_sdata = b << (8 * addr[2:0]);
        for (int i = 0; i < w; i++) begin
          mmem[addr[11:0] + i]   = b[8*i +: 8];
          exp_smask[addr[2:0] + i] = 1'b1;
        end
      end
      7'h13: begin
        res    = a + imm_i;
        writes = 1'b1;
      end
      7'h1b: begin
        val    = a + imm_i;
        res    = {{32{val[31]}}, val[31:0]};
        writes = 1'b1;
      end
      7'h33: begin
        res    = ins[30] ? a - b : a + b;
        writes = 1'b1;
      end
      default: writes = 1'b0;
    endcase
    exp_pc    = m_pc;
    exp_rd    = ins[11:7];
    exp_wen   = writes && (ins[11:7] != 5'd0);
    exp_wdata = res;
    if (exp_wen) begin
      xreg[ins[11:7]] = res;
    end
    m_pc = npc;
  endtask

  // outputs are sampled mid-cycle where they are settled
  always @(negedge clk) begin
    if (rst) begin
      cyc = 0;
      check("commit_valid", commit_valid, 1'b0);
      check("dmem_ren", dmem_ren, 1'b0);
      check("dmem_wen", dmem_wen, 1'b0);
      check("inst_addr", inst_addr, RESET_PC);
    end else begin
      cyc = cyc + 1;
      // fetch in cycle 1 of every five, memory in cycle 4, commit in cycle 5
      check("commit_valid", commit_valid, (cyc % 5) == 0);
      check("dmem_ren", dmem_ren, ((cyc % 5) == 4) && exp_load);
      check("dmem_wen", dmem_wen, ((cyc % 5) == 4) && exp_store);
      if ((cyc % 5) == 1) begin
        check("inst_addr", inst_addr, exp_pc);
      end
      if (dmem_ren) begin
        check("dmem_addr", dmem_addr, exp_addr);
      end
      if (dmem_wen) begin
        check("dmem_addr", dmem_addr, exp_addr);
        check("dmem_wdata", dmem_wdata, exp_sdata);
        check("dmem_wmask", dmem_wmask, exp_smask);
      end
      if (commit_valid) begin
        check("commit.pc", commit.pc, exp_pc);
        check("commit.rd", commit.rd, exp_rd);
        check("commit.wen", commit.wen, exp_wen);
        if (exp_wen) begin
          check("commit.wdata", commit.wdata, exp_wdata);
        end
        n_commits = n_commits + 1;
        step_model();
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    fail_run("timeout: the core stopped committing before the run was complete");
  end

  initial begin
    logic [31:0] r;
    for (int i = 0; i < 4096; i++) begin
      r       = $random(seed);
      dmem[i] = r[7:0];
      mmem[i] = r[7:0];
    end
    for (int i = 0; i < 32; i++) begin
      xreg[i] = '0;
    end
    m_pc = RESET_PC;
    gen_program();
    step_model();
    repeat (RST_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst = 1'b0;
    wait (n_commits == N_COMMITS);
    if (exp_pc == FINAL_PC) begin
      $display("** PASS **");
      $finish;
    end else begin
      fail_run("the program never reached its final self-loop");
    end
  end

endmodule

`default_nettype wire
